// ==== run.sh ====
#!/bin/sh
# build and run the back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f vlog.f --top-module tb_backend -o sim_backend \
	> build.log 2>&1 \
	&& ./obj_dir/sim_backend > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^=== PASS ===$" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/backend_checker.sv ====
`timescale 1ns/10ps

module backend_checker
	import rvseed_isa_pkg::*;
	import rvseed_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      retire_i,
	input  logic [reg_addr_width-1:0] retire_rd_i,
	input  logic [xlen-1:0]           retire_data_i,
	input  logic [xlen-1:0]           retire_pc_i,
	input  logic                      ebreak_i,
	input  logic [xlen-1:0]           rs_data_i
);

	logic [133:0] exp_q [$]; // {ebreak, rd, data, pc}
	logic [133:0] head;
	logic [63:0]  last_pc;   // pipeline register keeps pc while nothing retires
	int test_errs = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	task automatic push_expect(input logic [4:0] rd, input logic [63:0] data,
			input logic [63:0] pc, input logic eb);
		exp_q.push_back({eb, rd, data, pc});
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic int failed_tests();
		return tests_failed;
	endfunction

	task automatic compare_retire(input logic [133:0] want);
		if (retire_rd_i !== want[132:128] || retire_data_i !== want[127:64] ||
				retire_pc_i !== want[63:0] || ebreak_i !== want[133]) begin
			$display("Mismatch at %0t: retire rd %0d data %h pc %h eb %b, want %0d %h %h %b",
				$time, retire_rd_i, retire_data_i, retire_pc_i, ebreak_i,
				want[132:128], want[127:64], want[63:0], want[133]);
			test_errs++;
		end
	endtask

	// outputs only change at posedge, so the falling edge is a quiet point
	always @(negedge clk) begin
		if (!rst_n) begin
			last_pc = def_reset_pc;
		end else begin
			if (ebreak_i && !retire_i) begin
				$display("Error at %0t: ebreak_o high without a retirement", $time);
				test_errs++;
			end
			if (!retire_i && retire_pc_i !== last_pc) begin
				$display("Mismatch at %0t: retire pc %h moved without a retirement, want %h",
					$time, retire_pc_i, last_pc);
				test_errs++;
			end
			if (retire_i) begin
				last_pc = retire_pc_i;
				if (exp_q.size() == 0) begin
					$display("Error at %0t: retirement seen with nothing expected", $time);
					test_errs++;
				end else begin
					head = exp_q.pop_front();
					compare_retire(head);
				end
			end
		end
	end

	task automatic check_reg(input logic [4:0] rd, input logic [63:0] exp);
		if (rs_data_i !== exp) begin
			$display("Mismatch at %0t: x%0d reads %h, want %h", $time, rd, rs_data_i, exp);
			test_errs++;
		end
	endtask

	task automatic end_test(input int num);
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %0d passed", num);
		end else begin
			tests_failed++;
			$display("test %0d failed with %0d errors", num, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic report_counts();
		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
	endtask

endmodule

// ==== tb/backend_trace.txt ====
# test cmd op rd alu store_data wmask expected, all hex except test
# A alu, B alu with ebreak, S store, L load, H hold cycles in alu, R reg check, E end
1 R none 00 0 0 00 0
1 R none 01 0 0 00 0
1 R none 1f 0 0 00 0
1 E none 00 0 0 00 0
2 A none 01 deadbeef 0 00 deadbeef
2 A none 02 fffffffffffffff0 0 00 fffffffffffffff0
2 A none 00 ffff 0 00 ffff
2 R none 01 0 0 00 deadbeef
2 R none 02 0 0 00 fffffffffffffff0
2 R none 00 0 0 00 0
2 E none 00 0 0 00 0
3 S st 00 100 1122334455667788 ff 100
3 S st 00 100 aabbccddeeff0011 0f 100
3 L ld 03 100 0 00 11223344eeff0011
3 S st 00 104 0000a5c300000000 30 104
3 L ld 04 100 0 00 1122a5c3eeff0011
3 R none 03 0 0 00 11223344eeff0011
3 R none 04 0 0 00 1122a5c3eeff0011
3 E none 00 0 0 00 0
4 S st 00 200 80ff7f01fe8012cd ff 200
4 L lb 05 200 0 00 ffffffffffffffcd
4 L lbu 05 202 0 00 80
4 L lb 05 205 0 00 7f
4 L lbu 05 207 0 00 80
4 L lh 05 200 0 00 12cd
4 L lh 05 202 0 00 fffffffffffffe80
4 L lhu 05 206 0 00 80ff
4 L lh 05 204 0 00 7f01
4 L lw 05 200 0 00 fffffffffe8012cd
4 L lw 05 204 0 00 ffffffff80ff7f01
4 L lwu 05 200 0 00 fe8012cd
4 L lwu 05 204 0 00 80ff7f01
4 R none 05 0 0 00 80ff7f01
4 E none 00 0 0 00 0
5 H none 00 3 0 00 0
5 S st 00 300 0123456789abcdef ff 300
5 H none 00 4 0 00 0
5 A none 06 55 0 00 55
5 L ld 07 300 0 00 0123456789abcdef
5 R none 06 0 0 00 55
5 R none 07 0 0 00 0123456789abcdef
5 E none 00 0 0 00 0
6 B none 08 1234 0 00 1234
6 A none 09 5678 0 00 5678
6 R none 08 0 0 00 1234
6 E none 00 0 0 00 0

// ==== tb/tb_backend.sv ====
`timescale 1ns/10ps

module tb_backend
	import rvseed_isa_pkg::*;
();

	logic clk, rst_n, wen, ebreak, hold;
	logic [4:0] rd, rs_addr;
	logic [63:0] alu_res, store_data, pc;
	logic [7:0] wmask;
	mem_op_e mem_op;

	logic retire, ebreak_out;
	logic [4:0] retire_rd;
	logic [63:0] retire_data, retire_pc, rs_data;

	int fd, n, tnum, hold_left;
	bit aborted;
	logic [31:0] cmd, op_name;
	logic [63:0] f_rd, f_alu, f_sdata, f_mask, f_exp;
	logic [8*160-1:0] skip_line;

	rvseed_backend_top dut (
		.clk(clk), .rst_n(rst_n),
		.wen_i(wen), .rd_i(rd), .alu_res_i(alu_res), .store_data_i(store_data),
		.wmask_i(wmask), .mem_op_i(mem_op), .pc_i(pc), .ebreak_i(ebreak),
		.hold_i(hold), .rs_addr_i(rs_addr),
		.retire_o(retire), .retire_rd_o(retire_rd), .retire_data_o(retire_data),
		.retire_pc_o(retire_pc), .ebreak_o(ebreak_out), .rs_data_o(rs_data)
	);

	backend_checker chk (
		.clk(clk), .rst_n(rst_n), .retire_i(retire), .retire_rd_i(retire_rd),
		.retire_data_i(retire_data), .retire_pc_i(retire_pc), .ebreak_i(ebreak_out),
		.rs_data_i(rs_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic mem_op_e op_from_name(input logic [31:0] name);
		case (name)
			32'("lb"):  return mop_lb;
			32'("lh"):  return mop_lh;
			32'("lw"):  return mop_lw;
			32'("ld"):  return mop_ld;
			32'("lbu"): return mop_lbu;
			32'("lhu"): return mop_lhu;
			32'("lwu"): return mop_lwu;
			32'("st"):  return mop_store;
			default:    return mop_none;
		endcase
	endfunction

	// present one instruction, held first if an H line asked for it
	task automatic issue(input logic w, input logic eb);
		wen = w;
		rd = f_rd[4:0];
		alu_res = f_alu;
		store_data = f_sdata;
		wmask = f_mask[7:0];
		mem_op = op_from_name(op_name);
		ebreak = eb;
		if (hold_left > 0) begin
			hold = 1'b1;
			repeat (hold_left) @(negedge clk);
			hold_left = 0;
		end
		hold = 1'b0;
		chk.push_expect(f_rd[4:0], f_exp, pc, eb);
		@(negedge clk);
		hold = 1'b1; // bubble while idle
		store_data = ~f_sdata; // junk on the idle bus must never reach memory
		pc = pc + 64'd4;
	endtask

	task automatic wait_drain();
		int cnt;
		cnt = 0;
		while (chk.pending() != 0 && cnt < 20) begin
			@(negedge clk);
			cnt++;
		end
		if (chk.pending() != 0) begin
			$display("Timeout in test %0d: expected retirement did not arrive in 20 cycles",
				tnum);
			aborted = 1'b1;
		end
	endtask

	task automatic read_reg();
		wait_drain();
		@(negedge clk);
		rs_addr = f_rd[4:0];
		#1 chk.check_reg(f_rd[4:0], f_exp);
		@(negedge clk);
	endtask

	task automatic run_command();
		case (cmd)
			32'("A"): issue(1'b1, 1'b0);
			32'("B"): issue(1'b1, 1'b1);
			32'("L"): issue(1'b1, 1'b0);
			32'("S"): issue(1'b0, 1'b0);
			32'("H"): hold_left = int'(f_alu[31:0]);
			32'("R"): read_reg();
			32'("E"): begin
				wait_drain();
				chk.end_test(tnum);
			end
			default: begin
				$display("Error: unknown trace command in test %0d", tnum);
				aborted = 1'b1;
			end
		endcase
	endtask

	initial begin
		rst_n = 1'b0;
		hold = 1'b1;
		wen = 1'b0;
		ebreak = 1'b0;
		rd = '0;
		rs_addr = '0;
		alu_res = '0;
		store_data = '0;
		wmask = '0;
		mem_op = mop_none;
		pc = 64'h1000;
		hold_left = 0;
		aborted = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		fd = $fopen("tb/backend_trace.txt", "r");
		if (fd == 0) begin
			$display("Error: could not open tb/backend_trace.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			n = $fscanf(fd, "%d %s %s %h %h %h %h %h\n",
				tnum, cmd, op_name, f_rd, f_alu, f_sdata, f_mask, f_exp);
			if (n == 8) begin
				run_command();
			end else begin
				n = $fgets(skip_line, fd); // comment or blank line
			end
		end
		chk.report_counts();
		if (aborted || chk.failed_tests() != 0) begin
			$display("=== FAIL ===");
		end else begin
			$display("=== PASS ===");
		end
		$finish;
	end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/10ps

module mem_stage
	import rvseed_isa_pkg::*;
	import rvseed_cfg_pkg::*;
#(
	parameter int unsigned DMEM_DEPTH = def_dmem_depth
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            hold_i,
	input  logic [xlen-1:0] addr_i,       // byte address from the alu
	input  logic [xlen-1:0] store_data_i,
	input  logic [7:0]      wmask_i,      // one bit per byte lane
	input  mem_op_e         mem_op_i,
	output logic [xlen-1:0] load_word_o   // whole aligned word, lane picked later
);

	localparam int unsigned IDX_W = $clog2(DMEM_DEPTH);

	logic [xlen-1:0]  dmem [DMEM_DEPTH];
	logic [IDX_W-1:0] word_idx;
	logic             is_load;
	logic             do_store;

	// low three bits select the byte, upper bits beyond depth wrap
	assign word_idx = addr_i[3 +: IDX_W];

	assign is_load  = (mem_op_i != mop_none) && (mem_op_i != mop_store);
	assign do_store = (mem_op_i == mop_store) && !hold_i;

	// byte masked write
	always_ff @(posedge clk) begin
		if (do_store) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask_i[b]) begin
					dmem[word_idx][b*8 +: 8] <= store_data_i[b*8 +: 8];
				end
			end
		end
	end

	// registered read, frozen under hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_word_o <= '0;
		end else if (is_load && !hold_i) begin
			load_word_o <= dmem[word_idx];
		end
	end

endmodule

// ==== verilog/mem_wb_regs.sv ====
`timescale 1ns/10ps

module mem_wb_regs
	import rvseed_isa_pkg::*;
	import rvseed_cfg_pkg::*;
#(
	parameter logic [xlen-1:0] RESET_PC = def_reset_pc
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      hold_i,     // freeze the stage

	input  logic                      wen_i,      // register write enable
	input  logic [reg_addr_width-1:0] rd_i,
	input  logic [xlen-1:0]           alu_res_i,
	input  logic [2:0]                addr_lo_i,  // byte offset for lane select
	input  mem_op_e                   mem_op_i,
	input  logic [xlen-1:0]           pc_i,
	input  logic                      ebreak_i,
	input  logic                      valid_i,

	output logic                      wen_o,
	output logic [reg_addr_width-1:0] rd_o,
	output logic [xlen-1:0]           alu_res_o,
	output logic [2:0]                addr_lo_o,
	output mem_op_e                   mem_op_o,
	output logic [xlen-1:0]           pc_o,
	output logic                      ebreak_o,
	output logic                      valid_o
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen_o     <= 1'b0;
			rd_o      <= '0;
			alu_res_o <= '0;
			addr_lo_o <= 3'd0;
			mem_op_o  <= mop_none;
			pc_o      <= RESET_PC;
			ebreak_o  <= 1'b0;
		end else if (hold_i) begin
			// held instruction stays put
			wen_o     <= wen_o;
			rd_o      <= rd_o;
			alu_res_o <= alu_res_o;
			addr_lo_o <= addr_lo_o;
			mem_op_o  <= mem_op_o;
			pc_o      <= pc_o;
			ebreak_o  <= ebreak_o;
		end else begin
			wen_o     <= wen_i;
			rd_o      <= rd_i;
			alu_res_o <= alu_res_i;
			addr_lo_o <= addr_lo_i;
			mem_op_o  <= mem_op_i;
			pc_o      <= pc_i;
			ebreak_o  <= ebreak_i;
		end
	end

	// valid reloads even under hold, so held fields never retire twice
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps

module regfile
	import rvseed_isa_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      we_i,
	input  logic [reg_addr_width-1:0] waddr_i,
	input  logic [xlen-1:0]           wdata_i,
	input  logic [reg_addr_width-1:0] raddr_i,
	output logic [xlen-1:0]           rdata_o
);

	localparam int unsigned NUM_REGS = 2 ** reg_addr_width;

	logic [xlen-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin // x0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational read, new value visible right after the write edge
	assign rdata_o = regs[raddr_i];

endmodule

// ==== verilog/rvseed_backend_top.sv ====
`timescale 1ns/10ps

module rvseed_backend_top
	import rvseed_isa_pkg::*;
	import rvseed_cfg_pkg::*;
#(
	parameter int unsigned     DMEM_DEPTH = def_dmem_depth,
	parameter logic [xlen-1:0] RESET_PC   = def_reset_pc
) (
	input  logic                      clk,
	input  logic                      rst_n,

	// instruction from execute
	input  logic                      wen_i,
	input  logic [reg_addr_width-1:0] rd_i,
	input  logic [xlen-1:0]           alu_res_i,    // also the memory address
	input  logic [xlen-1:0]           store_data_i,
	input  logic [7:0]                wmask_i,
	input  mem_op_e                   mem_op_i,
	input  logic [xlen-1:0]           pc_i,
	input  logic                      ebreak_i,
	input  logic                      hold_i,
	input  logic [reg_addr_width-1:0] rs_addr_i,

	output logic                      retire_o,
	output logic [reg_addr_width-1:0] retire_rd_o,
	output logic [xlen-1:0]           retire_data_o,
	output logic [xlen-1:0]           retire_pc_o,
	output logic                      ebreak_o,
	output logic [xlen-1:0]           rs_data_o
);

	logic [xlen-1:0]           load_word;

	logic                      wb_wen;
	logic [reg_addr_width-1:0] wb_rd;
	logic [xlen-1:0]           wb_alu_res;
	logic [2:0]                wb_addr_lo;
	mem_op_e                   wb_mem_op;
	logic [xlen-1:0]           wb_pc;
	logic                      wb_ebreak;
	logic                      wb_valid;

	logic                      rf_we;
	logic [reg_addr_width-1:0] rf_waddr;
	logic [xlen-1:0]           rf_wdata;

	mem_stage #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) u_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.hold_i       (hold_i),
		.addr_i       (alu_res_i),
		.store_data_i (store_data_i),
		.wmask_i      (wmask_i),
		.mem_op_i     (mem_op_i),
		.load_word_o  (load_word)
	);

	mem_wb_regs #(
		.RESET_PC (RESET_PC)
	) u_mem_wb_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.hold_i    (hold_i),
		.wen_i     (wen_i),
		.rd_i      (rd_i),
		.alu_res_i (alu_res_i),
		.addr_lo_i (alu_res_i[2:0]),
		.mem_op_i  (mem_op_i),
		.pc_i      (pc_i),
		.ebreak_i  (ebreak_i),
		.valid_i   (!hold_i),    // held instruction is not taken yet
		.wen_o     (wb_wen),
		.rd_o      (wb_rd),
		.alu_res_o (wb_alu_res),
		.addr_lo_o (wb_addr_lo),
		.mem_op_o  (wb_mem_op),
		.pc_o      (wb_pc),
		.ebreak_o  (wb_ebreak),
		.valid_o   (wb_valid)
	);

	wb_unit u_wb_unit (
		.wen_i       (wb_wen),
		.rd_i        (wb_rd),
		.alu_res_i   (wb_alu_res),
		.addr_lo_i   (wb_addr_lo),
		.mem_op_i    (wb_mem_op),
		.pc_i        (wb_pc),
		.ebreak_i    (wb_ebreak),
		.valid_i     (wb_valid),
		.load_word_i (load_word),
		.rf_we_o     (rf_we),
		.rf_waddr_o  (rf_waddr),
		.rf_wdata_o  (rf_wdata),
		.retire_o    (retire_o),
		.retire_pc_o (retire_pc_o),
		.ebreak_o    (ebreak_o)
	);

	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.we_i    (rf_we),
		.waddr_i (rf_waddr),
		.wdata_i (rf_wdata),
		.raddr_i (rs_addr_i),
		.rdata_o (rs_data_o)
	);

	// retire port mirrors the register write port
	assign retire_rd_o   = rf_waddr;
	assign retire_data_o = rf_wdata;

endmodule

// ==== verilog/rvseed_cfg_pkg.sv ====
package rvseed_cfg_pkg;

	// data memory size in 64-bit words, power of two
	localparam int unsigned def_dmem_depth = 256;

	// pc shown on the retire port until the first instruction
	localparam logic [63:0] def_reset_pc = 64'h0000_0000_8000_0000;

endpackage

// ==== verilog/rvseed_isa_pkg.sv ====
package rvseed_isa_pkg;

	// integer data path width, one word
	localparam int unsigned xlen = 64;

	// register file address width
	localparam int unsigned reg_addr_width = 5;

	// memory access opcodes carried down the back end
	typedef enum logic [3:0] {
		mop_none  = 4'd0, // no memory access, alu result writes back
		mop_lb    = 4'd1,
		mop_lh    = 4'd2,
		mop_lw    = 4'd3,
		mop_ld    = 4'd4,
		mop_lbu   = 4'd5,
		mop_lhu   = 4'd6,
		mop_lwu   = 4'd7,
		mop_store = 4'd8  // byte lanes picked by wmask
	} mem_op_e;

endpackage

// ==== verilog/wb_unit.sv ====
`timescale 1ns/10ps

module wb_unit
	import rvseed_isa_pkg::*;
(
	input  logic                      wen_i,
	input  logic [reg_addr_width-1:0] rd_i,
	input  logic [xlen-1:0]           alu_res_i,
	input  logic [2:0]                addr_lo_i,
	input  mem_op_e                   mem_op_i,
	input  logic [xlen-1:0]           pc_i,
	input  logic                      ebreak_i,
	input  logic                      valid_i,
	input  logic [xlen-1:0]           load_word_i,  // registered memory word

	output logic                      rf_we_o,
	output logic [reg_addr_width-1:0] rf_waddr_o,
	output logic [xlen-1:0]           rf_wdata_o,
	output logic                      retire_o,
	output logic [xlen-1:0]           retire_pc_o,
	output logic                      ebreak_o
);

	logic [7:0]  byte_lane;
	logic [15:0] half_lane;
	logic [31:0] word_lane;

	// misaligned offsets fall back to the naturally aligned lane
	assign byte_lane = load_word_i[{addr_lo_i, 3'b000} +: 8];
	assign half_lane = load_word_i[{addr_lo_i[2:1], 4'b0000} +: 16];
	assign word_lane = addr_lo_i[2] ? load_word_i[63:32] : load_word_i[31:0];

	always_comb begin
		case (mem_op_i)
			mop_lb:  rf_wdata_o = {{56{byte_lane[7]}}, byte_lane};
			mop_lh:  rf_wdata_o = {{48{half_lane[15]}}, half_lane};
			mop_lw:  rf_wdata_o = {{32{word_lane[31]}}, word_lane};
			mop_ld:  rf_wdata_o = load_word_i;
			mop_lbu: rf_wdata_o = {56'd0, byte_lane};
			mop_lhu: rf_wdata_o = {48'd0, half_lane};
			mop_lwu: rf_wdata_o = {32'd0, word_lane};
			default: rf_wdata_o = alu_res_i; // alu ops and stores
		endcase
	end

	assign rf_we_o     = valid_i && wen_i;
	assign rf_waddr_o  = rd_i;
	assign retire_o    = valid_i;
	assign retire_pc_o = pc_i;
	assign ebreak_o    = valid_i && ebreak_i;

endmodule

// ==== vlog.f ====
verilog/rvseed_isa_pkg.sv
verilog/rvseed_cfg_pkg.sv
verilog/mem_stage.sv
verilog/mem_wb_regs.sv
verilog/wb_unit.sv
verilog/regfile.sv
verilog/rvseed_backend_top.sv
tb/backend_checker.sv
tb/tb_backend.sv
